// File: project.f
src/cpuIsaPkg.sv
src/cpuPipePkg.sv
src/pipeReg.sv
src/instrDecoder.sv
src/regFile.sv
src/hazardUnit.sv
src/execUnit.sv
src/datapath.sv
tests/datapathTb.sv

// File: Bender.yml
package:
  name: pipeCore

sources:
  - src/cpuIsaPkg.sv
  - src/cpuPipePkg.sv
  - src/pipeReg.sv
  - src/instrDecoder.sv
  - src/regFile.sv
  - src/hazardUnit.sv
  - src/execUnit.sv
  - src/datapath.sv
  - target: test
    files:
      - tests/datapathTb.sv

// File: tests/datapathTb.sv
`timescale 1ns/1ns

module datapathTb
    import cpuIsaPkg::*;
;

    typedef struct packed {
        logic [XLEN-1:0]       pc;
        logic [REG_ADDR_W-1:0] num;
        logic [XLEN-1:0]       data;
    } retireT;

    typedef struct packed {
        logic [XLEN-1:0] addr;
        logic [XLEN-1:0] data;
    } storeT;

    logic                  clk, reset_i, resetWindow;
    logic [XLEN-1:0]       instrF_i, pcF_o, memRdataM_i, memAddrM_o, memWdataM_o;
    logic                  instEnF_o, memEnM_o;
    logic [3:0]            memWenM_o, debugWbRfWen_o;
    logic [XLEN-1:0]       debugWbPc_o, debugWbRfWdata_o;
    logic [REG_ADDR_W-1:0] debugWbRfWnum_o;

    logic [31:0] imem [256];
    logic [31:0] dmem [256];
    logic [31:0] lcgState;
    logic [31:0] loopPc;
    int          progLen;
    retireT      expQ[$];
    storeT       stQ[$];
    retireT      expRetire;
    storeT       expStore;
    logic        haveRetire, haveStore;

    datapath UUT (.*);

    assign instrF_i    = imem[pcF_o[9:2]];       // combinational fetch
    assign memRdataM_i = dmem[memAddrM_o[9:2]];

    always @(posedge clk) begin
        if (memWenM_o == 4'hf) dmem[memAddrM_o[9:2]] <= memWdataM_o;
    end

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic stopRun(string line);
        $display("%s", line);
        $display("SOME TESTS FAILED");
        $fatal(1, "run stopped");
    endtask

    function automatic logic [31:0] lcgNext();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState;
    endfunction

    // fill word mixes every address bit
    function automatic logic [31:0] fillWord(logic [31:0] addr);
        return {addr[15:0], addr[31:16]} ^ (addr * 32'h9e37_79b9) ^ 32'h0f1e_2d3c;
    endfunction

    function automatic logic [31:0] rOp(logic [5:0] fn, logic [4:0] rs, logic [4:0] rt,
                                        logic [4:0] rd, logic [4:0] sa);
        return {OP_SPECIAL, rs, rt, rd, sa, fn};
    endfunction

    function automatic logic [31:0] iOp(logic [5:0] op, logic [4:0] rs, logic [4:0] rt,
                                        logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [4:0] pickSrc();
        return 5'd1 + 5'((lcgNext() >> 13) % 8);  // one of $1..$8
    endfunction

    function automatic logic [31:0] pcOf(int idx);
        return RESET_PC + 32'(idx) * 32'd4;
    endfunction

    task automatic put(logic [31:0] word);
        imem[progLen] = word;
        progLen++;
    endtask

    task automatic buildProgram();
        logic [5:0]  rFn [11];
        logic [5:0]  iOpc [7];
        logic [31:0] v;
        rFn  = '{FN_ADDU, FN_SUBU, FN_AND, FN_OR, FN_XOR, FN_NOR, FN_SLT, FN_SLTU,
                 FN_SLL, FN_SRL, FN_SRA};
        iOpc = '{OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ANDI, OP_ORI, OP_XORI, OP_LUI};
        for (int r = 1; r <= 8; r++) begin   // random register seeds
            v = lcgNext();
            put(iOp(OP_LUI, 5'd0, 5'(r), v[31:16]));
            put(iOp(OP_ORI, 5'(r), 5'(r), v[15:0]));
        end
        foreach (rFn[k]) put(rOp(rFn[k], pickSrc(), pickSrc(), 5'(9 + k), 5'(lcgNext() >> 7)));
        foreach (iOpc[k]) put(iOp(iOpc[k], pickSrc(), 5'(20 + k), 16'(lcgNext() >> 9)));
        put(rOp(FN_ADDU, 5'd1, 5'd2, 5'd0, 5'd0));   // write to $0
        put(rOp(FN_OR, 5'd0, 5'd0, 5'd21, 5'd0));    // $0 must read back zero
        put(rOp(FN_ADDU, 5'd1, 5'd2, 5'd22, 5'd0));  // forwarding at distance 1..3
        put(rOp(FN_SUBU, 5'd22, 5'd3, 5'd23, 5'd0));
        put(rOp(FN_XOR, 5'd4, 5'd22, 5'd24, 5'd0));
        put(rOp(FN_OR, 5'd22, 5'd23, 5'd25, 5'd0));
        put(iOp(OP_ADDIU, 5'd0, 5'd28, 16'h0100));   // data base
        put(iOp(OP_SW, 5'd28, 5'd1, 16'h0000));
        put(iOp(OP_LW, 5'd28, 5'd26, 16'h0000));     // store then load
        put(rOp(FN_ADDU, 5'd26, 5'd2, 5'd27, 5'd0)); // load-use
        put(iOp(OP_LW, 5'd28, 5'd26, 16'h0008));     // untouched fill word
        put(rOp(FN_XOR, 5'd3, 5'd26, 5'd27, 5'd0));
        put(iOp(OP_BEQ, 5'd1, 5'd1, 16'd2));         // taken
        put(iOp(OP_ADDIU, 5'd0, 5'd9, 16'h0011));    // delay slot
        put(iOp(OP_ADDIU, 5'd0, 5'd10, 16'h0bad));   // squashed
        put(iOp(OP_BNE, 5'd1, 5'd1, 16'd2));         // not taken
        put(iOp(OP_ADDIU, 5'd0, 5'd11, 16'h0022));
        put(iOp(OP_ADDIU, 5'd0, 5'd12, 16'h0033));   // fall through
        put(iOp(OP_BNE, 5'd1, 5'd2, 16'd2));
        put(iOp(OP_ADDIU, 5'd0, 5'd13, 16'h0044));
        put(iOp(OP_ADDIU, 5'd0, 5'd14, 16'h0bad));
        put(iOp(OP_BEQ, 5'd1, 5'd2, 16'd2));
        put(iOp(OP_ADDIU, 5'd0, 5'd15, 16'h0055));
        put(iOp(OP_ADDIU, 5'd0, 5'd16, 16'h0066));
        v = pcOf(progLen + 3);
        put({OP_J, v[27:2]});
        put(iOp(OP_ADDIU, 5'd0, 5'd17, 16'h0077));
        put(iOp(OP_ADDIU, 5'd0, 5'd18, 16'h0bad));
        v = pcOf(progLen + 3);
        put({OP_JAL, v[27:2]});
        put(iOp(OP_ADDIU, 5'd31, 5'd19, 16'h0008));  // slot reads $31 after jal
        put(iOp(OP_ADDIU, 5'd0, 5'd20, 16'h0bad));
        put(iOp(OP_ADDIU, 5'd31, 5'd29, 16'h0004));
        put(iOp(OP_ADDIU, 5'd0, 5'd30, 16'h7e57));   // sentinel
        loopPc = pcOf(progLen);
        put({OP_J, loopPc[27:2]});                    // park here forever
        put(32'h0);
    endtask

    // in-order architectural model with the branch delay slot
    task automatic runGolden();
        logic [31:0] gr [32];
        logic [31:0] gm [256];
        logic [31:0] pc, npc, nnpc, ins, val, addr, simm;
        logic [4:0]  rs, rt, dst, sa;
        logic        wr;
        int          steps;
        retireT      r;
        storeT       s;
        foreach (gr[i]) gr[i] = '0;
        foreach (gm[i]) gm[i] = dmem[i];
        pc    = RESET_PC;
        npc   = pc + 32'd4;
        steps = 0;
        while (pc != loopPc && steps < 1000) begin
            ins  = imem[pc[9:2]];
            rs   = ins[25:21];
            rt   = ins[20:16];
            sa   = ins[10:6];
            simm = {{16{ins[15]}}, ins[15:0]};
            wr   = 1'b1;
            dst  = rt;
            val  = '0;
            nnpc = npc + 32'd4;
            addr = gr[rs] + simm;
            case (ins[31:26])
                OP_SPECIAL: begin
                    dst = ins[15:11];
                    case (ins[5:0])
                        FN_ADDU: val = gr[rs] + gr[rt];
                        FN_SUBU: val = gr[rs] - gr[rt];
                        FN_AND:  val = gr[rs] & gr[rt];
                        FN_OR:   val = gr[rs] | gr[rt];
                        FN_XOR:  val = gr[rs] ^ gr[rt];
                        FN_NOR:  val = ~(gr[rs] | gr[rt]);
                        FN_SLT:  val = 32'($signed(gr[rs]) < $signed(gr[rt]));
                        FN_SLTU: val = 32'(gr[rs] < gr[rt]);
                        FN_SLL:  val = gr[rt] << sa;
                        FN_SRL:  val = gr[rt] >> sa;
                        FN_SRA:  val = $unsigned($signed(gr[rt]) >>> sa);
                        default: wr = 1'b0;
                    endcase
                end
                OP_ADDIU: val = addr;
                OP_SLTI:  val = 32'($signed(gr[rs]) < $signed(simm));
                OP_SLTIU: val = 32'(gr[rs] < simm);
                OP_ANDI:  val = gr[rs] & {16'b0, ins[15:0]};
                OP_ORI:   val = gr[rs] | {16'b0, ins[15:0]};
                OP_XORI:  val = gr[rs] ^ {16'b0, ins[15:0]};
                OP_LUI:   val = {ins[15:0], 16'b0};
                OP_LW:    val = gm[addr[9:2]];
                OP_SW: begin
                    wr = 1'b0;
                    gm[addr[9:2]] = gr[rt];
                    s.addr = addr;
                    s.data = gr[rt];
                    stQ.push_back(s);
                end
                OP_BEQ: begin
                    wr = 1'b0;
                    if (gr[rs] == gr[rt]) nnpc = pc + 32'd4 + (simm << 2);
                end
                OP_BNE: begin
                    wr = 1'b0;
                    if (gr[rs] != gr[rt]) nnpc = pc + 32'd4 + (simm << 2);
                end
                OP_J, OP_JAL: begin
                    wr   = (ins[31:26] == OP_JAL);
                    dst  = LINK_REG;
                    val  = pc + 32'd8;
                    nnpc = {pc[31:28], ins[25:0], 2'b00};
                end
                default: wr = 1'b0;
            endcase
            if (wr && dst != '0) begin
                gr[dst] = val;
                r.pc   = pc;
                r.num  = dst;
                r.data = val;
                expQ.push_back(r);
            end
            pc  = npc;
            npc = nnpc;
            steps++;
        end
    endtask

    task automatic loadHeads();
        haveRetire = (expQ.size() > 0);
        haveStore  = (stQ.size() > 0);
        if (haveRetire) expRetire = expQ[0];
        if (haveStore) expStore = stQ[0];
    endtask

    // retires to $0 are nops or discarded writes, not traced
    always @(posedge clk) begin
        if (debugWbRfWen_o != '0 && debugWbRfWnum_o != '0 && haveRetire) void'(expQ.pop_front());
        if (memWenM_o != '0 && haveStore) void'(stQ.pop_front());
        loadHeads();
    end

    resetState: assert property (@(posedge clk) resetWindow |->
        (pcF_o == RESET_PC && !instEnF_o && !memEnM_o && debugWbRfWen_o == '0))
        else stopRun($sformatf("** Error at %0t ns: bad state during reset", $time));

    retireOrder: assert property (@(posedge clk)
        (debugWbRfWen_o != '0 && debugWbRfWnum_o != '0) |-> (haveRetire &&
        debugWbPc_o == expRetire.pc && debugWbRfWnum_o == expRetire.num &&
        debugWbRfWdata_o == expRetire.data))
        else stopRun($sformatf("** Error at %0t ns: retire pc %h r%0d = %h, expected %h r%0d = %h",
            $time, $sampled(debugWbPc_o), $sampled(debugWbRfWnum_o),
            $sampled(debugWbRfWdata_o), $sampled(expRetire.pc), $sampled(expRetire.num),
            $sampled(expRetire.data)));

    wordStrobe: assert property (@(posedge clk) disable iff (reset_i)
        memWenM_o inside {4'h0, 4'hf})
        else stopRun($sformatf("** Error at %0t ns: partial write strobe %b", $time,
            $sampled(memWenM_o)));

    storeMatch: assert property (@(posedge clk) (memWenM_o != '0) |-> (haveStore &&
        memEnM_o && memAddrM_o == expStore.addr && memWdataM_o == expStore.data))
        else stopRun($sformatf("** Error at %0t ns: store %h to %h, expected %h to %h",
            $time, $sampled(memWdataM_o), $sampled(memAddrM_o),
            $sampled(expStore.data), $sampled(expStore.addr)));

    initial begin
        int waitCycles;
        reset_i     = 1'b1;
        resetWindow = 1'b0;
        lcgState    = 32'h4da1_e650;
        progLen     = 0;
        foreach (imem[i]) imem[i] = '0;
        foreach (dmem[i]) dmem[i] = fillWord({22'b0, 8'(i), 2'b00});
        buildProgram();
        runGolden();
        loadHeads();
        @(posedge clk);
        resetWindow = 1'b1;
        repeat (7) @(posedge clk);
        @(negedge clk);
        reset_i = 1'b0;
        @(posedge clk);                    // first cycle out of reset still checked
        @(negedge clk);
        resetWindow = 1'b0;
        waitCycles = 0;
        while ((expQ.size() > 0 || stQ.size() > 0) && waitCycles < 3000) begin
            @(negedge clk);
            waitCycles++;
        end
        if (expQ.size() == 0 && stQ.size() == 0) begin
            $display("ALL TESTS PASSED");
            $finish;
        end else begin
            stopRun("timeout: the final sentinel instruction did not retire in time");
        end
    end

endmodule

// File: src/datapath.sv
`timescale 1ns/1ns

module datapath
    import cpuIsaPkg::*;
    import cpuPipePkg::*;
(
    input  logic                  clk,
    input  logic                  reset_i,
    input  logic [XLEN-1:0]       instrF_i,
    output logic [XLEN-1:0]       pcF_o,
    output logic                  instEnF_o,
    input  logic [XLEN-1:0]       memRdataM_i,
    output logic                  memEnM_o,
    output logic [XLEN-1:0]       memAddrM_o,
    output logic [3:0]            memWenM_o,
    output logic [XLEN-1:0]       memWdataM_o,
    output logic [XLEN-1:0]       debugWbPc_o,
    output logic [3:0]            debugWbRfWen_o,
    output logic [REG_ADDR_W-1:0] debugWbRfWnum_o,
    output logic [XLEN-1:0]       debugWbRfWdata_o
);

    ifIdT  ifIdQ;
    idExT  idExD, idExQ;
    exMemT exMemD, exMemQ;
    memWbT memWbD, memWbQ;

    ctrlT                  ctrlD;
    logic [XLEN-1:0]       immD, rd1D, rd2D, targetE, resultM;
    logic [REG_ADDR_W-1:0] dstD, rsD, rtD;
    logic                  stallD, bubbleE, redirectE;
    fwdSelT                fwdA, fwdB;

    // fetch enable rises one cycle after reset, PC waits for it
    always_ff @(posedge clk) begin
        if (reset_i) begin
            pcF_o     <= RESET_PC;
            instEnF_o <= 1'b0;
        end else begin
            instEnF_o <= 1'b1;
            if (instEnF_o && !stallD) begin
                pcF_o <= redirectE ? targetE : pcF_o + 32'd4;
            end
        end
    end

    // a redirect squashes the wrong-path fetch, the delay slot is already in D
    pipeReg #(.payloadT(ifIdT)) ifIdReg (
        .clk(clk), .reset_i(reset_i),
        .stall_i(stallD), .flush_i(redirectE || !instEnF_o),
        .d_i('{pc: pcF_o, instr: instrF_i}), .q_o(ifIdQ)
    );

    instrDecoder decoder (
        .instr_i(ifIdQ.instr), .ctrl_o(ctrlD), .imm_o(immD), .dst_o(dstD)
    );

    // unused source fields are zeroed so they never stall or forward
    assign rsD = ctrlD.jump ? '0 : ifIdQ.instr[25:21];
    assign rtD = (ctrlD.jump || (ctrlD.immSel && !ctrlD.memWrite)) ? '0 : ifIdQ.instr[20:16];

    regFile regs (
        .clk(clk), .reset_i(reset_i),
        .we_i(exMemQ.regWriteEn), .waddr_i(exMemQ.dst), .wdata_i(resultM),
        .raddr1_i(rsD), .raddr2_i(rtD), .rdata1_o(rd1D), .rdata2_o(rd2D)
    );

    assign idExD = '{
        pc: ifIdQ.pc, pcPlus4: ifIdQ.pc + 32'd4, rs: rsD, rt: rtD, dst: dstD,
        rd1: rd1D, rd2: rd2D, imm: immD, sa: ifIdQ.instr[10:6], ctrl: ctrlD
    };

    pipeReg #(.payloadT(idExT)) idExReg (
        .clk(clk), .reset_i(reset_i), .stall_i(1'b0), .flush_i(bubbleE),
        .d_i(idExD), .q_o(idExQ)
    );

    hazardUnit hazard (
        .rsD_i(rsD), .rtD_i(rtD), .rsE_i(idExQ.rs), .rtE_i(idExQ.rt),
        .dstE_i(idExQ.dst), .memReadE_i(idExQ.ctrl.memRead),
        .dstM_i(exMemQ.dst), .regWriteEnM_i(exMemQ.regWriteEn),
        .dstW_i(memWbQ.dst), .regWriteEnW_i(memWbQ.regWriteEn),
        .stallD_o(stallD), .bubbleE_o(bubbleE), .fwdA_o(fwdA), .fwdB_o(fwdB)
    );

    execUnit exec (
        .ex_i(idExQ), .fwdA_i(fwdA), .fwdB_i(fwdB),
        .memFwd_i(exMemQ.aluOut), .wbFwd_i(memWbQ.result),
        .exMem_o(exMemD), .redirect_o(redirectE), .target_o(targetE)
    );

    pipeReg #(.payloadT(exMemT)) exMemReg (
        .clk(clk), .reset_i(reset_i), .stall_i(1'b0), .flush_i(1'b0),
        .d_i(exMemD), .q_o(exMemQ)
    );

    // memory stage, word access only
    assign memEnM_o    = exMemQ.memRead || exMemQ.memWrite;
    assign memAddrM_o  = exMemQ.aluOut;
    assign memWenM_o   = {4{exMemQ.memWrite}};
    assign memWdataM_o = exMemQ.storeData;
    assign resultM     = exMemQ.memRead ? memRdataM_i : exMemQ.aluOut;

    assign memWbD = '{dst: exMemQ.dst, regWriteEn: exMemQ.regWriteEn, result: resultM};

    pipeReg #(.payloadT(memWbT)) memWbReg (
        .clk(clk), .reset_i(reset_i), .stall_i(1'b0), .flush_i(1'b0),
        .d_i(memWbD), .q_o(memWbQ)
    );

    // retire trace follows the register file write
    assign debugWbPc_o      = exMemQ.pc;
    assign debugWbRfWen_o   = {4{exMemQ.regWriteEn}};
    assign debugWbRfWnum_o  = exMemQ.dst;
    assign debugWbRfWdata_o = resultM;

    // the load-use stall must keep load data off the M bypass, which lacks it
    noLoadOnMemBypass: assert property (
        @(posedge clk) disable iff (reset_i)
        exMemQ.memRead |-> (fwdA != FWD_MEM && fwdB != FWD_MEM)
    ) else $error("datapath: load result taken from the memory-stage bypass");

endmodule

// File: src/execUnit.sv
`timescale 1ns/1ns

module execUnit
    import cpuIsaPkg::*;
    import cpuPipePkg::*;
(
    input  idExT            ex_i,
    input  fwdSelT          fwdA_i,
    input  fwdSelT          fwdB_i,
    input  logic [XLEN-1:0] memFwd_i,
    input  logic [XLEN-1:0] wbFwd_i,
    output exMemT           exMem_o,
    output logic            redirect_o,
    output logic [XLEN-1:0] target_o
);

    logic [XLEN-1:0] srcA;
    logic [XLEN-1:0] rtVal;
    logic [XLEN-1:0] srcB;
    logic [XLEN-1:0] aluRes;
    logic            operandsEq;
    logic            taken;

    function automatic logic [XLEN-1:0] bypass(fwdSelT sel, logic [XLEN-1:0] regVal);
        case (sel)
            FWD_MEM: return memFwd_i;
            FWD_WB:  return wbFwd_i;
            default: return regVal;
        endcase
    endfunction

    always_comb begin
        srcA  = bypass(fwdA_i, ex_i.rd1);
        rtVal = bypass(fwdB_i, ex_i.rd2);   // also the store data
    end

    assign srcB = ex_i.ctrl.immSel ? ex_i.imm : rtVal;

    always_comb begin
        case (ex_i.ctrl.aluOp)
            ALU_ADD:  aluRes = srcA + srcB;
            ALU_SUB:  aluRes = srcA - srcB;
            ALU_AND:  aluRes = srcA & srcB;
            ALU_OR:   aluRes = srcA | srcB;
            ALU_XOR:  aluRes = srcA ^ srcB;
            ALU_NOR:  aluRes = ~(srcA | srcB);
            ALU_SLT:  aluRes = {{(XLEN-1){1'b0}}, $signed(srcA) < $signed(srcB)};
            ALU_SLTU: aluRes = {{(XLEN-1){1'b0}}, srcA < srcB};
            ALU_SLL:  aluRes = srcB << ex_i.sa;
            ALU_SRL:  aluRes = srcB >> ex_i.sa;
            ALU_SRA:  aluRes = $unsigned($signed(srcB) >>> ex_i.sa);
            default:  aluRes = srcB;   // lui with its immediate already shifted
        endcase
    end

    // branch compare on the bypassed rs/rt
    assign operandsEq = (srcA == rtVal);
    assign taken      = (ex_i.ctrl.branchEq && operandsEq) ||
                        (ex_i.ctrl.branchNe && !operandsEq);
    assign redirect_o = taken || ex_i.ctrl.jump;
    assign target_o   = ex_i.ctrl.jump ?
                        {ex_i.pcPlus4[31:28], ex_i.imm[25:0], 2'b00} :
                        ex_i.pcPlus4 + {ex_i.imm[XLEN-3:0], 2'b00};

    assign exMem_o = '{
        pc:         ex_i.pc,
        aluOut:     ex_i.ctrl.link ? ex_i.pcPlus4 + 32'd4 : aluRes,  // return past the slot
        storeData:  rtVal,
        dst:        ex_i.dst,
        memRead:    ex_i.ctrl.memRead,
        memWrite:   ex_i.ctrl.memWrite,
        regWriteEn: ex_i.ctrl.regWriteEn
    };

endmodule

// File: src/hazardUnit.sv
`timescale 1ns/1ns

module hazardUnit
    import cpuIsaPkg::*;
    import cpuPipePkg::*;
(
    input  logic [REG_ADDR_W-1:0] rsD_i,
    input  logic [REG_ADDR_W-1:0] rtD_i,
    input  logic [REG_ADDR_W-1:0] rsE_i,
    input  logic [REG_ADDR_W-1:0] rtE_i,
    input  logic [REG_ADDR_W-1:0] dstE_i,
    input  logic                  memReadE_i,
    input  logic [REG_ADDR_W-1:0] dstM_i,
    input  logic                  regWriteEnM_i,
    input  logic [REG_ADDR_W-1:0] dstW_i,
    input  logic                  regWriteEnW_i,
    output logic                  stallD_o,
    output logic                  bubbleE_o,
    output fwdSelT                fwdA_o,
    output fwdSelT                fwdB_o
);

    // youngest producer wins
    function automatic fwdSelT fwdFor(logic [REG_ADDR_W-1:0] src);
        if (src == '0) return FWD_REG;
        if (regWriteEnM_i && dstM_i == src) return FWD_MEM;
        if (regWriteEnW_i && dstW_i == src) return FWD_WB;
        return FWD_REG;
    endfunction

    always_comb begin
        fwdA_o = fwdFor(rsE_i);
        fwdB_o = fwdFor(rtE_i);
    end

    // a load in E feeding D holds D one cycle so its data comes from WB
    assign stallD_o  = memReadE_i && dstE_i != '0 && (dstE_i == rsD_i || dstE_i == rtD_i);
    assign bubbleE_o = stallD_o;

endmodule

// File: src/regFile.sv
`timescale 1ns/1ns

module regFile
    import cpuIsaPkg::*;
(
    input  logic                  clk,
    input  logic                  reset_i,
    input  logic                  we_i,
    input  logic [REG_ADDR_W-1:0] waddr_i,
    input  logic [XLEN-1:0]       wdata_i,
    input  logic [REG_ADDR_W-1:0] raddr1_i,
    input  logic [REG_ADDR_W-1:0] raddr2_i,
    output logic [XLEN-1:0]       rdata1_o,
    output logic [XLEN-1:0]       rdata2_o
);

    logic [XLEN-1:0] regs [32];

    // only $0 is cleared, the rest start undefined
    always_ff @(posedge clk) begin
        if (reset_i) begin
            regs[0] <= '0;
        end else if (we_i && waddr_i != '0) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    assign rdata1_o = regs[raddr1_i];  // no write-through, WB forward covers it
    assign rdata2_o = regs[raddr2_i];

    zeroReadsZero: assert property (
        @(posedge clk) disable iff (reset_i) (raddr1_i == '0) |-> (rdata1_o == '0)
    ) else $error("regFile: register zero read back nonzero");

endmodule

// File: src/instrDecoder.sv
`timescale 1ns/1ns

module instrDecoder
    import cpuIsaPkg::*;
    import cpuPipePkg::*;
(
    input  logic [XLEN-1:0]       instr_i,
    output ctrlT                  ctrl_o,
    output logic [XLEN-1:0]       imm_o,
    output logic [REG_ADDR_W-1:0] dst_o
);

    logic [5:0] opcode;
    logic [5:0] funct;

    assign opcode = instr_i[31:26];
    assign funct  = instr_i[5:0];

    always_comb begin
        ctrl_o = '0;
        imm_o  = {{16{instr_i[15]}}, instr_i[15:0]};  // sign extended by default
        dst_o  = instr_i[20:16];                       // rt
        case (opcode)
            OP_SPECIAL: begin
                ctrl_o.regWriteEn = 1'b1;
                dst_o             = instr_i[15:11];    // rd
                case (funct)
                    FN_ADDU: ctrl_o.aluOp = ALU_ADD;
                    FN_SUBU: ctrl_o.aluOp = ALU_SUB;
                    FN_AND:  ctrl_o.aluOp = ALU_AND;
                    FN_OR:   ctrl_o.aluOp = ALU_OR;
                    FN_XOR:  ctrl_o.aluOp = ALU_XOR;
                    FN_NOR:  ctrl_o.aluOp = ALU_NOR;
                    FN_SLT:  ctrl_o.aluOp = ALU_SLT;
                    FN_SLTU: ctrl_o.aluOp = ALU_SLTU;
                    FN_SLL:  ctrl_o.aluOp = ALU_SLL;
                    FN_SRL:  ctrl_o.aluOp = ALU_SRL;
                    FN_SRA:  ctrl_o.aluOp = ALU_SRA;
                    default: ctrl_o = '0;
                endcase
            end
            OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ANDI, OP_ORI, OP_XORI, OP_LUI: begin
                ctrl_o.immSel     = 1'b1;
                ctrl_o.regWriteEn = 1'b1;
                case (opcode)
                    OP_ADDIU: ctrl_o.aluOp = ALU_ADD;
                    OP_SLTI:  ctrl_o.aluOp = ALU_SLT;
                    OP_SLTIU: ctrl_o.aluOp = ALU_SLTU;
                    OP_ANDI:  ctrl_o.aluOp = ALU_AND;
                    OP_ORI:   ctrl_o.aluOp = ALU_OR;
                    OP_XORI:  ctrl_o.aluOp = ALU_XOR;
                    default:  ctrl_o.aluOp = ALU_PASSB;  // lui
                endcase
                if (opcode == OP_ANDI || opcode == OP_ORI || opcode == OP_XORI) begin
                    imm_o = {16'b0, instr_i[15:0]};
                end else if (opcode == OP_LUI) begin
                    imm_o = {instr_i[15:0], 16'b0};
                end
            end
            OP_LW: begin
                ctrl_o.immSel     = 1'b1;
                ctrl_o.memRead    = 1'b1;
                ctrl_o.regWriteEn = 1'b1;
            end
            OP_SW: begin
                ctrl_o.immSel   = 1'b1;
                ctrl_o.memWrite = 1'b1;
            end
            OP_BEQ: ctrl_o.branchEq = 1'b1;
            OP_BNE: ctrl_o.branchNe = 1'b1;
            OP_J, OP_JAL: begin
                ctrl_o.jump       = 1'b1;
                ctrl_o.link       = (opcode == OP_JAL);
                ctrl_o.regWriteEn = (opcode == OP_JAL);
                imm_o             = {6'b0, instr_i[25:0]};  // jump index
                dst_o             = LINK_REG;
            end
            default: ctrl_o = '0;
        endcase
    end

endmodule

// File: src/pipeReg.sv
`timescale 1ns/1ns

module pipeReg #(
    parameter type payloadT = logic
) (
    input  logic    clk,
    input  logic    reset_i,
    input  logic    stall_i,
    input  logic    flush_i,
    input  payloadT d_i,
    output payloadT q_o
);

    // an all-zero payload decodes as a nop in every stage
    always_ff @(posedge clk) begin
        if (reset_i || flush_i) begin
            q_o <= '0;
        end else if (!stall_i) begin
            q_o <= d_i;
        end
    end

    // hazard and redirect never hit the same stage register together
    stallFlushExclusive: assert property (
        @(posedge clk) disable iff (reset_i) !(stall_i && flush_i)
    ) else $error("pipeReg: stall and flush in the same cycle");

endmodule

// File: src/cpuPipePkg.sv
package cpuPipePkg;
    import cpuIsaPkg::*;

    typedef struct packed {
        aluOpT aluOp;
        logic  immSel;      // operand b is the immediate
        logic  memRead;
        logic  memWrite;
        logic  regWriteEn;
        logic  branchEq;
        logic  branchNe;
        logic  jump;        // j and jal
        logic  link;        // result is the return address
    } ctrlT;

    typedef enum logic [1:0] {
        FWD_REG = 2'd0,
        FWD_MEM = 2'd1,
        FWD_WB  = 2'd2
    } fwdSelT;

    typedef struct packed {
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] instr;
    } ifIdT;

    typedef struct packed {
        logic [XLEN-1:0]       pc;
        logic [XLEN-1:0]       pcPlus4;
        logic [REG_ADDR_W-1:0] rs;   // zero when unused
        logic [REG_ADDR_W-1:0] rt;
        logic [REG_ADDR_W-1:0] dst;
        logic [XLEN-1:0]       rd1;
        logic [XLEN-1:0]       rd2;
        logic [XLEN-1:0]       imm;
        logic [4:0]            sa;
        ctrlT                  ctrl;
    } idExT;

    typedef struct packed {
        logic [XLEN-1:0]       pc;
        logic [XLEN-1:0]       aluOut;     // also the load/store address
        logic [XLEN-1:0]       storeData;
        logic [REG_ADDR_W-1:0] dst;
        logic                  memRead;
        logic                  memWrite;
        logic                  regWriteEn;
    } exMemT;

    typedef struct packed {
        logic [REG_ADDR_W-1:0] dst;
        logic                  regWriteEn;
        logic [XLEN-1:0]       result;
    } memWbT;

endpackage

// File: src/cpuIsaPkg.sv
package cpuIsaPkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    localparam logic [XLEN-1:0]       RESET_PC = 32'hbfc0_0000;
    localparam logic [REG_ADDR_W-1:0] LINK_REG = 5'd31;  // jal writes here

    // primary opcodes
    localparam logic [5:0] OP_SPECIAL = 6'h00;
    localparam logic [5:0] OP_J       = 6'h02;
    localparam logic [5:0] OP_JAL     = 6'h03;
    localparam logic [5:0] OP_BEQ     = 6'h04;
    localparam logic [5:0] OP_BNE     = 6'h05;
    localparam logic [5:0] OP_ADDIU   = 6'h09;
    localparam logic [5:0] OP_SLTI    = 6'h0a;
    localparam logic [5:0] OP_SLTIU   = 6'h0b;
    localparam logic [5:0] OP_ANDI    = 6'h0c;
    localparam logic [5:0] OP_ORI     = 6'h0d;
    localparam logic [5:0] OP_XORI    = 6'h0e;
    localparam logic [5:0] OP_LUI     = 6'h0f;
    localparam logic [5:0] OP_LW      = 6'h23;
    localparam logic [5:0] OP_SW      = 6'h2b;

    // funct field, SPECIAL only
    localparam logic [5:0] FN_SLL  = 6'h00;
    localparam logic [5:0] FN_SRL  = 6'h02;
    localparam logic [5:0] FN_SRA  = 6'h03;
    localparam logic [5:0] FN_ADDU = 6'h21;
    localparam logic [5:0] FN_SUBU = 6'h23;
    localparam logic [5:0] FN_AND  = 6'h24;
    localparam logic [5:0] FN_OR   = 6'h25;
    localparam logic [5:0] FN_XOR  = 6'h26;
    localparam logic [5:0] FN_NOR  = 6'h27;
    localparam logic [5:0] FN_SLT  = 6'h2a;
    localparam logic [5:0] FN_SLTU = 6'h2b;

    // ALU_ADD must stay zero so a cleared control word is a nop
    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR,
        ALU_XOR, ALU_NOR, ALU_SLT, ALU_SLTU,
        ALU_SLL, ALU_SRL, ALU_SRA, ALU_PASSB
    } aluOpT;

endpackage
